// File: Bender.yml
package:
  name: core_exec

sources:
  - include_dirs:
      - design
    files:
      - design/rv_pkg.sv
      - design/core_idecode.sv
      - design/core_regfile.sv
      - design/core_alu.sv
      - design/core_exec_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/core_exec_sva.sv
      - verification/core_exec_tb.sv

// File: design/core_alu.sv
`timescale 1ns/1ns

`include "rv_macros.svh"

module core_alu (
	input  rv_pkg::alu_op_e     op,
	input  rv_pkg::br_cond_e    cond,
	input  logic [`RV_XLEN-1:0] a,
	input  logic [`RV_XLEN-1:0] b,
	input  logic [`RV_XLEN-1:0] rs1_val,
	input  logic [`RV_XLEN-1:0] rs2_val,
	input  logic [`RV_XLEN-1:0] pc,
	input  logic [`RV_XLEN-1:0] imm,
	output logic [`RV_XLEN-1:0] result,
	output logic [`RV_XLEN-1:0] br_target,
	output logic                br_taken
);
	import rv_pkg::*;

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;
	logic       br_eq;
	logic       br_lt;
	logic       br_ltu;

	assign shamt = b[4:0];
	assign lt_s  = ($signed(a) < $signed(b));
	assign lt_u  = (a < b);

	always_comb begin
		case (op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_SLL:    result = a << shamt;
			ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, lt_s};
			ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, lt_u};
			ALU_XOR:    result = a ^ b;
			ALU_SRL:    result = a >> shamt;
			ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
			ALU_OR:     result = a | b;
			ALU_AND:    result = a & b;
			ALU_PASS_B: result = b;
			ALU_LINK:   result = pc + `RV_XLEN'd4;
			default:    result = '0;
		endcase
	end

	// Branches compare the raw register values, never the muxed operands
	assign br_eq  = (rs1_val == rs2_val);
	assign br_lt  = ($signed(rs1_val) < $signed(rs2_val));
	assign br_ltu = (rs1_val < rs2_val);

	always_comb begin
		case (cond)
			BR_EQ:   br_taken = br_eq;
			BR_NE:   br_taken = !br_eq;
			BR_LT:   br_taken = br_lt;
			BR_GE:   br_taken = !br_lt;
			BR_LTU:  br_taken = br_ltu;
			BR_GEU:  br_taken = !br_ltu;
			default: br_taken = 1'b0;
		endcase
	end

	assign br_target = pc + imm;

endmodule

// File: design/core_exec_top.sv
`timescale 1ns/1ns

`include "rv_macros.svh"

module core_exec_top (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  instr_valid,
	input  logic [31:0]           instruction,
	input  logic [`RV_XLEN-1:0]   pc,
	output logic                  wb_valid,
	output logic [`RV_REG_AW-1:0] wb_addr,
	output logic [`RV_XLEN-1:0]   wb_data,
	output logic                  br_valid,
	output logic                  br_taken,
	output logic [`RV_XLEN-1:0]   br_target,
	output logic                  illegal
);
	import rv_pkg::*;

	logic [`RV_REG_AW-1:0] rs1_addr;
	logic [`RV_REG_AW-1:0] rs2_addr;
	logic [`RV_REG_AW-1:0] rd_addr;
	logic [`RV_XLEN-1:0]   rs1_data;
	logic [`RV_XLEN-1:0]   rs2_data;
	logic [`RV_XLEN-1:0]   imm;
	alu_op_e               alu_op;
	br_cond_e              br_cond;
	logic                  use_imm;
	logic                  use_pc;
	logic                  rd_we;
	logic                  is_branch;
	logic                  is_illegal;
	logic [`RV_XLEN-1:0]   op_a;
	logic [`RV_XLEN-1:0]   op_b;
	logic [`RV_XLEN-1:0]   result;
	logic [`RV_XLEN-1:0]   alu_br_target;
	logic                  alu_br_taken;
	logic                  wb_we;
	logic                  br_we;
	logic                  ill_we;

	core_idecode i_idecode (
		.instruction(instruction),
		.rs1_addr   (rs1_addr),
		.rs2_addr   (rs2_addr),
		.rd_addr    (rd_addr),
		.imm        (imm),
		.alu_op     (alu_op),
		.br_cond    (br_cond),
		.use_imm    (use_imm),
		.use_pc     (use_pc),
		.rd_we      (rd_we),
		.is_branch  (is_branch),
		.is_illegal (is_illegal)
	);

	assign op_a = use_pc ? pc : rs1_data;
	assign op_b = use_imm ? imm : rs2_data;

	// Decoder flags only count on a strobe cycle
	assign wb_we  = instr_valid & rd_we;
	assign br_we  = instr_valid & is_branch;
	assign ill_we = instr_valid & is_illegal;

	// Written on the same edge that loads wb_data
	core_regfile i_regfile (
		.clk   (clk),
		.arst_n(arst_n),
		.ra1   (rs1_addr),
		.ra2   (rs2_addr),
		.wa    (rd_addr),
		.we    (wb_we),
		.wd    (result),
		.rd1   (rs1_data),
		.rd2   (rs2_data)
	);

	core_alu i_alu (
		.op       (alu_op),
		.cond     (br_cond),
		.a        (op_a),
		.b        (op_b),
		.rs1_val  (rs1_data),
		.rs2_val  (rs2_data),
		.pc       (pc),
		.imm      (imm),
		.result   (result),
		.br_target(alu_br_target),
		.br_taken (alu_br_taken)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid  <= 1'b0;
			wb_addr   <= '0;
			wb_data   <= '0;
			br_valid  <= 1'b0;
			br_taken  <= 1'b0;
			br_target <= '0;
			illegal   <= 1'b0;
		end else begin
			wb_valid <= wb_we;    // One-cycle pulses
			br_valid <= br_we;
			illegal  <= ill_we;
			br_taken <= br_we & alu_br_taken;
			if (wb_we) begin
				wb_addr <= rd_addr;
				wb_data <= result;
			end
			if (br_we)
				br_target <= alu_br_target; // Held until the next branch
		end
	end

endmodule

// File: design/core_idecode.sv
`timescale 1ns/1ns

`include "rv_macros.svh"

module core_idecode (
	input  logic [31:0]           instruction,
	output logic [`RV_REG_AW-1:0] rs1_addr,
	output logic [`RV_REG_AW-1:0] rs2_addr,
	output logic [`RV_REG_AW-1:0] rd_addr,
	output logic [`RV_XLEN-1:0]   imm,
	output rv_pkg::alu_op_e       alu_op,
	output rv_pkg::br_cond_e      br_cond,
	output logic                  use_imm,
	output logic                  use_pc,
	output logic                  rd_we,
	output logic                  is_branch,
	output logic                  is_illegal
);
	import rv_pkg::*;

	opcode_e             opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic                rd_nz;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_s;
	logic [`RV_XLEN-1:0] imm_b;
	logic [`RV_XLEN-1:0] imm_u;
	logic [`RV_XLEN-1:0] imm_j;

	// funct3 to operation, alt selects SUB or SRA
	function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			3'b000:  op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode   = opcode_e'(instruction[6:0]);
	assign funct3   = instruction[14:12];
	assign funct7   = instruction[31:25];
	assign rd_addr  = instruction[11:7];
	assign rs1_addr = instruction[19:15];
	assign rs2_addr = instruction[24:20];
	assign rd_nz    = (rd_addr != '0);

	assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
	assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
	assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
			instruction[30:25], instruction[11:8], 1'b0}; // Halfword offset
	assign imm_u = {instruction[31:12], 12'b0};
	assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
			instruction[20], instruction[30:21], 1'b0};

	always_comb begin
		imm        = '0;
		alu_op     = ALU_ADD;
		br_cond    = BR_NONE;
		use_imm    = 1'b0;
		use_pc     = 1'b0;
		rd_we      = 1'b0;
		is_branch  = 1'b0;
		is_illegal = 1'b0;
		case (opcode)
			OP_R_ALU: begin
				alu_op = alu_from_funct(funct3, funct7[5]);
				rd_we  = rd_nz;
			end
			OP_I_ALU: begin
				// Only SRAI takes the alt bit, ADDI has no subtract form
				alu_op  = alu_from_funct(funct3, funct7[5] & (funct3 == 3'b101));
				imm     = imm_i; // Shifts use imm[4:0] as shamt
				use_imm = 1'b1;
				rd_we   = rd_nz;
			end
			OP_LUI: begin
				alu_op  = ALU_PASS_B;
				imm     = imm_u;
				use_imm = 1'b1;
				rd_we   = rd_nz;
			end
			OP_AUIPC: begin
				imm     = imm_u;
				use_imm = 1'b1;
				use_pc  = 1'b1;
				rd_we   = rd_nz;
			end
			OP_JAL: begin
				alu_op = ALU_LINK;
				imm    = imm_j;
				use_pc = 1'b1;
				rd_we  = rd_nz;
			end
			OP_BRANCH: begin
				imm = imm_b;
				if (funct3 == 3'b010 || funct3 == 3'b011) begin
					is_illegal = 1'b1; // Reserved branch codes
				end else begin
					br_cond   = br_cond_e'(funct3);
					is_branch = 1'b1;
				end
			end
			OP_STORE: begin
				imm        = imm_s;
				is_illegal = 1'b1; // No memory port
			end
			default: is_illegal = 1'b1;
		endcase
	end

endmodule

// File: design/core_regfile.sv
`timescale 1ns/1ns

`include "rv_macros.svh"

module core_regfile (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`RV_REG_AW-1:0] ra1,
	input  logic [`RV_REG_AW-1:0] ra2,
	input  logic [`RV_REG_AW-1:0] wa,
	input  logic                  we,
	input  logic [`RV_XLEN-1:0]   wd,
	output logic [`RV_XLEN-1:0]   rd1,
	output logic [`RV_XLEN-1:0]   rd2
);

	// x0 has no storage
	logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// Plain reads, a write shows up after its edge
	always_comb begin
		rd1 = '0;
		rd2 = '0;
		if (ra1 != '0)
			rd1 = regs[ra1];
		if (ra2 != '0)
			rd2 = regs[ra2];
	end

endmodule

// File: design/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Machine word, used for data and for addresses
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NREGS 32

// Width of the rs1, rs2 and rd fields
`define RV_REG_AW 5

`endif

// File: design/rv_pkg.sv
package rv_pkg;

	// Major opcodes, the low seven bits of the instruction
	typedef enum logic [6:0] {
		OP_I_ALU  = 7'b0010011,
		OP_R_ALU  = 7'b0110011,
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_BRANCH = 7'b1100011,
		OP_STORE  = 7'b0100011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10, // LUI
		ALU_LINK   = 4'd11  // JAL return address
	} alu_op_e;

	// Values follow the branch funct3 encoding
	typedef enum logic [2:0] {
		BR_EQ   = 3'b000,
		BR_NE   = 3'b001,
		BR_NONE = 3'b010, // Reserved funct3 code
		BR_LT   = 3'b100,
		BR_GE   = 3'b101,
		BR_LTU  = 3'b110,
		BR_GEU  = 3'b111
	} br_cond_e;

endpackage

// File: verification/core_exec_sva.sv
`timescale 1ns/1ns

`include "rv_macros.svh"

module core_exec_sva (
	input logic                  clk,
	input logic                  arst_n,
	input logic                  instr_valid,
	input logic                  wb_valid,
	input logic [`RV_REG_AW-1:0] wb_addr,
	input logic                  br_valid,
	input logic                  illegal
);

	a_wb_addr_nz: assert property (@(posedge clk) disable iff (!arst_n)
		wb_valid |-> wb_addr != '0)
		else $error("wb_valid with wb_addr zero");

	// At most one kind of result per instruction
	a_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({wb_valid, br_valid, illegal}))
		else $error("wb_valid, br_valid and illegal overlap");

	a_no_spurious: assert property (@(posedge clk) disable iff (!arst_n)
		!$past(instr_valid) |-> !(wb_valid || br_valid || illegal))
		else $error("Output valid without a preceding strobe");

endmodule

bind core_exec_top core_exec_sva i_sva (
	.clk        (clk),
	.arst_n     (arst_n),
	.instr_valid(instr_valid),
	.wb_valid   (wb_valid),
	.wb_addr    (wb_addr),
	.br_valid   (br_valid),
	.illegal    (illegal)
);

// File: verification/core_exec_tb.sv
`timescale 1ns/1ns

`include "rv_macros.svh"

module core_exec_tb;
	import rv_pkg::*;

	localparam int N_INSTR    = 33 + 201 + 61 + 101 + 74; // Issue slots over all tests
	localparam int TIMEOUT_NS = (N_INSTR + 4 + 100) * 4;

	logic                  clk;
	logic                  arst_n;
	logic                  instr_valid;
	logic [31:0]           instruction;
	logic [`RV_XLEN-1:0]   pc;
	logic                  wb_valid;
	logic [`RV_REG_AW-1:0] wb_addr;
	logic [`RV_XLEN-1:0]   wb_data;
	logic                  br_valid;
	logic                  br_taken;
	logic [`RV_XLEN-1:0]   br_target;
	logic                  illegal;

	logic [`RV_XLEN-1:0] mregs [0:`RV_NREGS-1]; // Reference register array
	logic                exp_wb;
	logic                exp_br;
	logic                exp_ill;
	logic                exp_taken;
	logic [4:0]          exp_addr;
	logic [31:0]         exp_data;
	logic [31:0]         exp_target;
	int                  errors;
	int                  tests;
	int                  failed_tests;
	int                  test_start_errors;

	core_exec_top i_core_exec_top (
		.clk        (clk),
		.arst_n     (arst_n),
		.instr_valid(instr_valid),
		.instruction(instruction),
		.pc         (pc),
		.wb_valid   (wb_valid),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data),
		.br_valid   (br_valid),
		.br_taken   (br_taken),
		.br_target  (br_target),
		.illegal    (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Integer ISA rules for OP and OP-IMM
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] x, input logic [31:0] y);
		case (f3)
			3'd0:    return alt ? x - y : x + y;
			3'd1:    return x << y[4:0];
			3'd2:    return {31'b0, $signed(x) < $signed(y)};
			3'd3:    return {31'b0, x < y};
			3'd4:    return x ^ y;
			3'd5:    return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'd6:    return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] x,
			input logic [31:0] y);
		case (f3)
			3'd0:    return x == y;
			3'd1:    return x != y;
			3'd4:    return $signed(x) < $signed(y);
			3'd5:    return $signed(x) >= $signed(y);
			3'd6:    return x < y;
			default: return x >= y;
		endcase
	endfunction

	// Random OP or OP-IMM instruction with small rs fields so results get reused
	function automatic logic [31:0] make_alu(input logic [4:0] rd);
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		f3  = 3'($urandom_range(7, 0));
		alt = (f3 == 3'd0 || f3 == 3'd5) ? 1'($urandom_range(1, 0)) : 1'b0;
		rs1 = 5'($urandom_range(7, 0));
		rs2 = 5'($urandom_range(7, 0));
		if ($urandom_range(1, 0) == 1)
			return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_R_ALU};
		imm = 12'($urandom);
		if (f3 == 3'd1 || f3 == 3'd5)
			imm[11:5] = {1'b0, alt, 5'b0}; // Shift forms
		return {imm, rs1, f3, rd, OP_I_ALU};
	endfunction

	task automatic predict(input logic [31:0] ins, input logic [31:0] pc_v, input logic valid);
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] res;
		logic        wr;
		exp_wb    = 1'b0;
		exp_br    = 1'b0;
		exp_ill   = 1'b0;
		exp_taken = 1'b0;
		if (!valid)
			return;
		rd    = ins[11:7];
		f3    = ins[14:12];
		a     = mregs[ins[19:15]];
		b     = mregs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		res   = '0;
		wr    = 1'b1;
		case (ins[6:0])
			OP_R_ALU:  res = alu_ref(f3, ins[30], a, b);
			OP_I_ALU:  res = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i);
			OP_LUI:    res = {ins[31:12], 12'b0};
			OP_AUIPC:  res = pc_v + {ins[31:12], 12'b0};
			OP_JAL:    res = pc_v + 32'd4;
			OP_BRANCH: begin
				wr = 1'b0;
				if (f3 == 3'd2 || f3 == 3'd3) begin
					exp_ill = 1'b1;
				end else begin
					exp_br     = 1'b1;
					exp_taken  = branch_ref(f3, a, b);
					exp_target = pc_v + imm_b;
				end
			end
			default: begin
				wr      = 1'b0;
				exp_ill = 1'b1; // Stores and unknown opcodes
			end
		endcase
		if (wr && rd != 5'd0) begin
			exp_wb    = 1'b1;
			exp_addr  = rd;
			exp_data  = res;
			mregs[rd] = res;
		end
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
		errors++;
	endtask

	task automatic check_outputs();
		if (wb_valid !== exp_wb)
			report_mismatch("wb_valid", 32'(wb_valid), 32'(exp_wb));
		if (br_valid !== exp_br)
			report_mismatch("br_valid", 32'(br_valid), 32'(exp_br));
		if (illegal !== exp_ill)
			report_mismatch("illegal", 32'(illegal), 32'(exp_ill));
		if (exp_wb && wb_addr !== exp_addr)
			report_mismatch("wb_addr", 32'(wb_addr), 32'(exp_addr));
		if (exp_wb && wb_data !== exp_data)
			report_mismatch("wb_data", wb_data, exp_data);
		if (exp_br && br_taken !== exp_taken)
			report_mismatch("br_taken", 32'(br_taken), 32'(exp_taken));
		if (exp_br && br_target !== exp_target)
			report_mismatch("br_target", br_target, exp_target);
	endtask

	// Check the previous slot and drive the next one
	task automatic issue(input logic [31:0] ins, input logic [31:0] pc_v, input logic valid);
		@(negedge clk);
		check_outputs();
		instr_valid = valid;
		instruction = ins;
		pc          = pc_v;
		predict(ins, pc_v, valid);
	endtask

	task automatic end_test(input string name);
		issue(32'h0, 32'h0, 1'b0);
		tests++;
		if (errors == test_start_errors) begin
			$display("Test %s done, no errors", name);
		end else begin
			failed_tests++;
			$display("Test %s done, %0d errors", name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	task automatic run_reset_test();
		@(negedge clk);
		if (wb_valid !== 1'b0 || br_valid !== 1'b0 || illegal !== 1'b0)
			report_mismatch("valids", {wb_valid, br_valid, illegal}, 32'h0);
		if (br_taken !== 1'b0)
			report_mismatch("br_taken", 32'(br_taken), 32'h0);
		if (wb_addr !== '0)
			report_mismatch("wb_addr", 32'(wb_addr), 32'h0);
		if (wb_data !== '0)
			report_mismatch("wb_data", wb_data, 32'h0);
		if (br_target !== '0)
			report_mismatch("br_target", br_target, 32'h0);
		for (int r = 0; r < `RV_NREGS; r++)
			issue({12'd0, 5'(r), 3'd0, 5'd1, OP_I_ALU}, 32'h0, 1'b1); // ADDI x1, xr, 0
		end_test("reset");
	endtask

	task automatic run_upper_test();
		logic [4:0]  rd;
		logic [20:0] jimm;
		logic [31:0] pcv;
		for (int n = 0; n < 60; n++) begin
			rd   = 5'($urandom_range(31, 1));
			pcv  = $urandom & 32'hffff_fffc;
			jimm = 21'($urandom) & ~21'd1;
			case (n % 3)
				0:       issue({20'($urandom), rd, OP_LUI}, pcv, 1'b1);
				1:       issue({20'($urandom), rd, OP_AUIPC}, pcv, 1'b1);
				default: issue({jimm[20], jimm[10:1], jimm[11], jimm[19:12], rd, OP_JAL},
						pcv, 1'b1);
			endcase
		end
		end_test("upper_jal");
	endtask

	task automatic run_branch_test();
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [12:0] bimm;
		for (int n = 0; n < 100; n++) begin
			rs1  = 5'($urandom_range(7, 1));
			rs2  = ($urandom_range(1, 0) == 1) ? rs1 : 5'($urandom_range(7, 1));
			f3   = 3'($urandom_range(5, 0));
			if (f3 >= 3'd2)
				f3 = f3 + 3'd2; // Skip the reserved codes
			bimm = 13'($urandom) & ~13'd1;
			issue({bimm[12], bimm[10:5], rs2, rs1, f3, bimm[4:1], bimm[11], OP_BRANCH},
				$urandom & 32'hffff_fffc, 1'b1);
		end
		end_test("branch");
	endtask

	task automatic run_zero_test();
		logic [31:0] ins;
		for (int n = 0; n < 20; n++)
			issue(make_alu(5'd0), 32'h0, 1'b1);
		issue({12'd0, 5'd0, 3'd0, 5'd5, OP_I_ALU}, 32'h0, 1'b1); // x5 gets x0
		for (int n = 0; n < 20; n++) begin
			ins = $urandom;
			case (n < 10 ? 3'd5 : 3'($urandom_range(4, 0)))
				3'd0:    ins[6:0] = 7'b0000011; // Load
				3'd1:    ins[6:0] = 7'b1100111; // JALR
				3'd2:    ins[6:0] = 7'b0001111;
				3'd3:    ins[6:0] = 7'b1110011;
				3'd4:    ins[6:0] = 7'b0101111;
				default: ins[6:0] = OP_STORE;
			endcase
			issue(ins, 32'h0, 1'b1);
		end
		// Read every register back unchanged
		for (int r = 0; r < `RV_NREGS; r++)
			issue({12'd0, 5'(r), 3'd0, 5'(r), OP_I_ALU}, 32'h0, 1'b1);
		end_test("reg_zero");
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout, the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Test failures found");
		$finish;
	end

	initial begin
		void'($urandom(26545));
		arst_n            = 1'b0;
		instr_valid       = 1'b0;
		instruction       = '0;
		pc                = '0;
		errors            = 0;
		tests             = 0;
		failed_tests      = 0;
		test_start_errors = 0;
		predict(32'h0, 32'h0, 1'b0);
		for (int r = 0; r < `RV_NREGS; r++)
			mregs[r] = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		run_reset_test();
		for (int n = 0; n < 200; n++)
			issue(make_alu(5'($urandom_range(7, 1))), $urandom, 1'b1);
		end_test("alu");
		run_upper_test();
		run_branch_test();
		run_zero_test();
		@(negedge clk);
		check_outputs(); // Last idle slot

		$display("Tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+design
design/rv_pkg.sv
design/core_idecode.sv
design/core_regfile.sv
design/core_alu.sv
design/core_exec_top.sv
verification/core_exec_sva.sv
verification/core_exec_tb.sv
